/* Makefile */
TOP = tb_mem_bus

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -Wno-fatal -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	if echo "$$out" | grep -q "No errors"; then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir

/* bus_sram.sv */
`timescale 1ns/1ps

module bus_sram
    import mem_bus_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 256,
    parameter int unsigned LATENCY   = 2
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  req_valid,
    output logic  req_ready,
    input  addr_t req_addr,
    input  logic  req_wen,
    input  word_t req_wdata,
    output logic  resp_valid,
    output word_t resp_rdata,
    output logic  resp_error
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(LATENCY + 1);

    word_t mem [MEM_WORDS];

    logic             busy;
    logic [CNT_W-1:0] lat_cnt;
    logic             accept;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    // response payload captured at the accept edge
    word_t rdata_q;
    logic  error_q;

    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;
    assign in_range  = (req_addr < ADDR_W'(MEM_WORDS));
    assign idx       = req_addr[IDX_W-1:0];

    // last countdown cycle carries the response
    assign resp_valid = busy && (lat_cnt == CNT_W'(1));
    assign resp_rdata = rdata_q;
    assign resp_error = error_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            lat_cnt <= CNT_W'(LATENCY);
        end else if (busy) begin
            if (lat_cnt == CNT_W'(1)) begin
                busy <= 1'b0;
            end
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    // array and payload
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= in_range ? mem[idx] : '0;
            error_q <= in_range ? RESP_OK : RESP_ERR;
            // out of range writes are dropped
            if (req_wen && in_range) begin
                mem[idx] <= req_wdata;
            end
        end
    end

endmodule

/* mem_bus_arbiter.sv */
`timescale 1ns/1ps

module mem_bus_arbiter
    import mem_bus_pkg::*;
#(
    parameter int unsigned IBURST_MAX = 8
) (
    input  logic  clk,
    input  logic  rst_n,

    // instruction port
    input  logic  i_req_valid,
    output logic  i_req_ready,
    input  addr_t i_req_addr,
    input  logic  i_req_wen,
    input  word_t i_req_wdata,
    output logic  i_resp_valid,
    output addr_t i_resp_addr,
    output word_t i_resp_rdata,
    output logic  i_resp_error,

    // data port
    input  logic  d_req_valid,
    output logic  d_req_ready,
    input  addr_t d_req_addr,
    input  logic  d_req_wen,
    input  word_t d_req_wdata,
    output logic  d_resp_valid,
    output addr_t d_resp_addr,
    output word_t d_resp_rdata,
    output logic  d_resp_error,

    // memory port
    output logic  mem_req_valid,
    input  logic  mem_req_ready,
    output addr_t mem_req_addr,
    output logic  mem_req_wen,
    output word_t mem_req_wdata,
    input  logic  mem_resp_valid,
    input  word_t mem_resp_rdata,
    input  logic  mem_resp_error
);

    localparam int RUN_W = $clog2(IBURST_MAX + 1);

    typedef enum logic [2:0] {
        I_CHECK,
        I_WAIT_READY,
        I_WAIT_RESP,
        D_CHECK,
        D_WAIT_READY,
        D_WAIT_RESP
    } state_t;

    state_t           state;
    logic [RUN_W-1:0] run_cnt;

    // held copy of the request taken in each check state
    addr_t s_i_addr;
    logic  s_i_wen;
    word_t s_i_wdata;
    addr_t s_d_addr;
    logic  s_d_wen;
    word_t s_d_wdata;

    assign i_req_ready = (state == I_CHECK);
    assign d_req_ready = (state == D_CHECK);

    // check states pass the port straight through, wait states replay the copy
    always_comb begin
        mem_req_valid = 1'b0;
        mem_req_addr  = '0;
        mem_req_wen   = 1'b0;
        mem_req_wdata = '0;
        case (state)
            I_CHECK: begin
                mem_req_valid = i_req_valid;
                mem_req_addr  = i_req_addr;
                mem_req_wen   = i_req_wen;
                mem_req_wdata = i_req_wdata;
            end
            I_WAIT_READY: begin
                mem_req_valid = 1'b1;
                mem_req_addr  = s_i_addr;
                mem_req_wen   = s_i_wen;
                mem_req_wdata = s_i_wdata;
            end
            D_CHECK: begin
                mem_req_valid = d_req_valid;
                mem_req_addr  = d_req_addr;
                mem_req_wen   = d_req_wen;
                mem_req_wdata = d_req_wdata;
            end
            D_WAIT_READY: begin
                mem_req_valid = 1'b1;
                mem_req_addr  = s_d_addr;
                mem_req_wen   = s_d_wen;
                mem_req_wdata = s_d_wdata;
            end
            default: begin
                mem_req_valid = 1'b0;
            end
        endcase
    end

    // response goes back to whichever port owns the transaction
    assign i_resp_valid = (state == I_WAIT_RESP) && mem_resp_valid;
    assign i_resp_addr  = s_i_addr;
    assign i_resp_rdata = mem_resp_rdata;
    assign i_resp_error = mem_resp_error;

    assign d_resp_valid = (state == D_WAIT_RESP) && mem_resp_valid;
    assign d_resp_addr  = s_d_addr;
    assign d_resp_rdata = mem_resp_rdata;
    assign d_resp_error = mem_resp_error;

    // request copies
    always_ff @(posedge clk) begin
        if (state == I_CHECK) begin
            s_i_addr  <= i_req_addr;
            s_i_wen   <= i_req_wen;
            s_i_wdata <= i_req_wdata;
        end
        if (state == D_CHECK) begin
            s_d_addr  <= d_req_addr;
            s_d_wen   <= d_req_wen;
            s_d_wdata <= d_req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= I_CHECK;
            run_cnt <= '0;
        end else begin
            case (state)
                I_CHECK: begin
                    if (!i_req_valid) begin
                        state <= D_CHECK;
                    end else if (!mem_req_ready) begin
                        state <= I_WAIT_READY;
                    end else begin
                        state <= I_WAIT_RESP;
                    end
                end
                I_WAIT_READY: begin
                    if (mem_req_ready) begin
                        state <= I_WAIT_RESP;
                    end
                end
                I_WAIT_RESP: begin
                    if (mem_resp_valid) begin
                        run_cnt <= run_cnt + 1'b1;
                        // data gets the next turn once the instruction run is complete
                        if (run_cnt == RUN_W'(IBURST_MAX - 1)) begin
                            state <= D_CHECK;
                        end else begin
                            state <= I_CHECK;
                        end
                    end
                end
                D_CHECK: begin
                    run_cnt <= '0;
                    if (!d_req_valid) begin
                        state <= I_CHECK;
                    end else if (!mem_req_ready) begin
                        state <= D_WAIT_READY;
                    end else begin
                        state <= D_WAIT_RESP;
                    end
                end
                D_WAIT_READY: begin
                    if (mem_req_ready) begin
                        state <= D_WAIT_RESP;
                    end
                end
                D_WAIT_RESP: begin
                    if (mem_resp_valid) begin
                        state <= I_CHECK;
                    end
                end
                default: begin
                    state <= I_CHECK;
                end
            endcase
        end
    end

endmodule

/* mem_bus_golden.txt */
# phase port(i/d) wen addr(hex) wdata(hex) exp_rdata(hex) exp_error
# 1 data writes, 2 data readback, 3 instruction reads, 4 out of range, 5 data starvation
1 d 1 00000005 a5a50005 00000000 0
1 d 1 00000010 deadbeef 00000000 0
1 d 1 00000023 01234567 00000000 0
1 d 1 00000040 89abcdef 00000000 0
1 d 1 0000007f 7f7f0000 00000000 0
1 d 1 00000080 80000001 00000000 0
1 d 1 000000ff ffff00ff 00000000 0
1 d 1 00000010 cafef00d 00000000 0
2 d 0 00000005 00000000 a5a50005 0
2 d 0 00000010 00000000 cafef00d 0
2 d 0 00000023 00000000 01234567 0
2 d 0 00000040 00000000 89abcdef 0
2 d 0 0000007f 00000000 7f7f0000 0
2 d 0 00000080 00000000 80000001 0
2 d 0 000000ff 00000000 ffff00ff 0
3 i 0 00000010 00000000 cafef00d 0
3 i 0 00000023 00000000 01234567 0
3 i 0 00000080 00000000 80000001 0
3 i 0 000000ff 00000000 ffff00ff 0
3 d 1 00000030 5eed0030 00000000 0
3 d 0 00000030 00000000 5eed0030 0
3 d 1 00000031 5eed0031 00000000 0
3 d 0 00000031 00000000 5eed0031 0
4 d 1 00000105 bad00105 00000000 1
4 d 0 00000005 00000000 a5a50005 0
4 i 0 00001000 00000000 00000000 1
4 i 1 000001ff bad001ff 00000000 1
4 i 0 000000ff 00000000 ffff00ff 0
5 i 0 00000005 00000000 a5a50005 0
5 i 0 00000010 00000000 cafef00d 0
5 i 0 00000023 00000000 01234567 0
5 i 0 00000040 00000000 89abcdef 0
5 i 0 0000007f 00000000 7f7f0000 0
5 i 0 00000080 00000000 80000001 0
5 i 0 000000ff 00000000 ffff00ff 0
5 i 0 00000005 00000000 a5a50005 0
5 i 0 00000010 00000000 cafef00d 0
5 i 0 00000023 00000000 01234567 0
5 i 0 00000040 00000000 89abcdef 0
5 i 0 0000007f 00000000 7f7f0000 0
5 i 0 00000080 00000000 80000001 0
5 i 0 000000ff 00000000 ffff00ff 0
5 d 0 00000030 00000000 5eed0030 0

/* mem_bus_pkg.sv */
package mem_bus_pkg;

    // bus widths shared by the arbiter, the SRAM and the testbench
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // word address, one unit per data word
    typedef logic [ADDR_W-1:0] addr_t;

    // data word on both request and response
    typedef logic [DATA_W-1:0] word_t;

    // resp_error encoding
    // an access at or above the SRAM depth reports RESP_ERR,
    // and a write to such an address is dropped
    localparam logic RESP_OK  = 1'b0;
    localparam logic RESP_ERR = 1'b1;

endpackage

/* mem_bus_top.sv */
`timescale 1ns/1ps

module mem_bus_top
    import mem_bus_pkg::*;
#(
    parameter int unsigned MEM_WORDS  = 256,
    parameter int unsigned LATENCY    = 2,
    parameter int unsigned IBURST_MAX = 8
) (
    input  logic  clk,
    input  logic  rst_n,

    // instruction port
    input  logic  i_req_valid,
    output logic  i_req_ready,
    input  addr_t i_req_addr,
    input  logic  i_req_wen,
    input  word_t i_req_wdata,
    output logic  i_resp_valid,
    output addr_t i_resp_addr,
    output word_t i_resp_rdata,
    output logic  i_resp_error,

    // data port
    input  logic  d_req_valid,
    output logic  d_req_ready,
    input  addr_t d_req_addr,
    input  logic  d_req_wen,
    input  word_t d_req_wdata,
    output logic  d_resp_valid,
    output addr_t d_resp_addr,
    output word_t d_resp_rdata,
    output logic  d_resp_error
);

    // arbiter to SRAM
    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_addr;
    logic  mem_req_wen;
    word_t mem_req_wdata;
    logic  mem_resp_valid;
    word_t mem_resp_rdata;
    logic  mem_resp_error;

    mem_bus_arbiter #(
        .IBURST_MAX(IBURST_MAX)
    ) u_arbiter (
        .clk(clk),
        .rst_n(rst_n),
        .i_req_valid(i_req_valid),
        .i_req_ready(i_req_ready),
        .i_req_addr(i_req_addr),
        .i_req_wen(i_req_wen),
        .i_req_wdata(i_req_wdata),
        .i_resp_valid(i_resp_valid),
        .i_resp_addr(i_resp_addr),
        .i_resp_rdata(i_resp_rdata),
        .i_resp_error(i_resp_error),
        .d_req_valid(d_req_valid),
        .d_req_ready(d_req_ready),
        .d_req_addr(d_req_addr),
        .d_req_wen(d_req_wen),
        .d_req_wdata(d_req_wdata),
        .d_resp_valid(d_resp_valid),
        .d_resp_addr(d_resp_addr),
        .d_resp_rdata(d_resp_rdata),
        .d_resp_error(d_resp_error),
        .mem_req_valid(mem_req_valid),
        .mem_req_ready(mem_req_ready),
        .mem_req_addr(mem_req_addr),
        .mem_req_wen(mem_req_wen),
        .mem_req_wdata(mem_req_wdata),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp_rdata(mem_resp_rdata),
        .mem_resp_error(mem_resp_error)
    );

    bus_sram #(
        .MEM_WORDS(MEM_WORDS),
        .LATENCY(LATENCY)
    ) u_sram (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(mem_req_valid),
        .req_ready(mem_req_ready),
        .req_addr(mem_req_addr),
        .req_wen(mem_req_wen),
        .req_wdata(mem_req_wdata),
        .resp_valid(mem_resp_valid),
        .resp_rdata(mem_resp_rdata),
        .resp_error(mem_resp_error)
    );

endmodule

/* tb_mem_bus.sv */
`timescale 1ns/1ps

module tb_mem_bus
    import mem_bus_pkg::*;
();

    // DUT parameters at their design defaults
    localparam int MEM_WORDS    = 256;
    localparam int LATENCY      = 2;
    localparam int IBURST_MAX   = 8;
    localparam int LAT_BOUND    = (IBURST_MAX + 1) * (LATENCY + 2);
    localparam int MAX_LINES    = 128;
    // phase with the instruction port saturated and one data request pending
    localparam int STARVE_PHASE = 5;

    logic  clk;
    logic  rst_n;
    logic  i_req_valid, i_req_ready, i_req_wen, i_resp_valid, i_resp_error;
    addr_t i_req_addr, i_resp_addr;
    word_t i_req_wdata, i_resp_rdata;
    logic  d_req_valid, d_req_ready, d_req_wen, d_resp_valid, d_resp_error;
    addr_t d_req_addr, d_resp_addr;
    word_t d_req_wdata, d_resp_rdata;

    // golden transactions
    int    line_phase [MAX_LINES];
    bit    line_is_d  [MAX_LINES];
    logic  line_wen   [MAX_LINES];
    addr_t line_addr  [MAX_LINES];
    word_t line_wdata [MAX_LINES];
    word_t line_rdata [MAX_LINES];
    logic  line_err   [MAX_LINES];
    int    n_lines, i_lines, d_lines, max_phase;

    logic [31:0] lcg_state;
    int cycle_count, cycle_limit;
    int i_resp_total, d_resp_total;

    mem_bus_top #(
        .MEM_WORDS(MEM_WORDS),
        .LATENCY(LATENCY),
        .IBURST_MAX(IBURST_MAX)
    ) u_mem_bus_top (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("Error: %s is %h, expected %h", name, got, exp));
    endtask

    function automatic int next_gap();
        logic [31:0] r;
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        r = lcg_state;
        return int'(r[17:16]);
    endfunction

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0) begin
            assert (cycle_count < cycle_limit)
                else abort_run($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    // count every response pulse to catch one routed to the wrong port
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (i_resp_valid) i_resp_total++;
            if (d_resp_valid) d_resp_total++;
        end
    end

    task automatic load_golden();
        int fd, code, phase, wen, err;
        string text, port_s;
        addr_t addr;
        word_t wdata, rdata;
        fd = $fopen("mem_bus_golden.txt", "r");
        assert (fd != 0) else abort_run("cannot open mem_bus_golden.txt");
        while (!$feof(fd)) begin
            code = $fgets(text, fd);
            if (code == 0 || text.len() < 2 || text[0] == "#") continue;
            code = $sscanf(text, "%d %s %d %h %h %h %d",
                           phase, port_s, wen, addr, wdata, rdata, err);
            assert (code == 7 && (port_s == "i" || port_s == "d") && n_lines < MAX_LINES)
                else abort_run({"bad line in golden file: ", text});
            line_phase[n_lines] = phase;
            line_is_d[n_lines]  = (port_s == "d");
            line_wen[n_lines]   = (wen != 0);
            line_addr[n_lines]  = addr;
            line_wdata[n_lines] = wdata;
            line_rdata[n_lines] = rdata;
            line_err[n_lines]   = (err != 0);
            if (port_s == "d") d_lines++;
            else i_lines++;
            if (phase > max_phase) max_phase = phase;
            n_lines++;
        end
        $fclose(fd);
    endtask

    task automatic drive_req(input bit is_d, input logic valid, input addr_t addr,
                             input logic wen, input word_t wdata);
        if (is_d) begin
            d_req_valid = valid;
            d_req_addr  = addr;
            d_req_wen   = wen;
            d_req_wdata = wdata;
        end else begin
            i_req_valid = valid;
            i_req_addr  = addr;
            i_req_wen   = wen;
            i_req_wdata = wdata;
        end
    endtask

    function automatic logic port_ready(input bit is_d);
        return is_d ? d_req_ready : i_req_ready;
    endfunction

    function automatic logic port_resp_valid(input bit is_d);
        return is_d ? d_resp_valid : i_resp_valid;
    endfunction

    task automatic check_reset_outputs();
        assert (i_resp_valid == 1'b0) else report_mismatch("i_resp_valid", 32'(i_resp_valid), 0);
        assert (d_resp_valid == 1'b0) else report_mismatch("d_resp_valid", 32'(d_resp_valid), 0);
        assert (d_req_ready == 1'b0) else report_mismatch("d_req_ready", 32'(d_req_ready), 0);
        assert (i_req_ready == 1'b1) else report_mismatch("i_req_ready", 32'(i_req_ready), 1);
    endtask

    task automatic check_resp(input bit is_d, input int k);
        string pfx;
        addr_t got_addr;
        word_t got_rdata;
        logic  got_err;
        pfx       = is_d ? "d" : "i";
        got_addr  = is_d ? d_resp_addr : i_resp_addr;
        got_rdata = is_d ? d_resp_rdata : i_resp_rdata;
        got_err   = is_d ? d_resp_error : i_resp_error;
        assert (got_addr == line_addr[k])
            else report_mismatch({pfx, "_resp_addr"}, got_addr, line_addr[k]);
        assert (got_err == line_err[k])
            else report_mismatch({pfx, "_resp_error"}, 32'(got_err), 32'(line_err[k]));
        // write data comes back unspecified
        if (!line_wen[k] && !line_err[k]) begin
            assert (got_rdata == line_rdata[k])
                else report_mismatch({pfx, "_resp_rdata"}, got_rdata, line_rdata[k]);
        end
    endtask

    task automatic check_bound(input bit is_d, input int waited);
        assert (waited <= LAT_BOUND)
            else abort_run($sformatf("%s port got no response within %0d cycles of its request",
                                     is_d ? "data" : "instruction", LAT_BOUND));
    endtask

    // one request from valid to response
    task automatic issue(input bit is_d, input int k);
        int waited;
        waited = 0;
        drive_req(is_d, 1'b1, line_addr[k], line_wen[k], line_wdata[k]);
        while (!port_ready(is_d)) begin
            @(negedge clk);
            waited++;
            check_bound(is_d, waited);
        end
        // handshake on the rising edge in between
        @(negedge clk);
        waited++;
        drive_req(is_d, 1'b0, '0, 1'b0, '0);
        while (!port_resp_valid(is_d)) begin
            @(negedge clk);
            waited++;
            check_bound(is_d, waited);
        end
        check_resp(is_d, k);
    endtask

    task automatic run_port(input bit is_d, input int phase);
        int gap;
        for (int k = 0; k < n_lines; k++) begin
            if (line_phase[k] == phase && line_is_d[k] == is_d) begin
                if (phase == STARVE_PHASE) begin
                    // data request lands in the middle of an instruction run
                    gap = is_d ? 4 : 0;
                end else begin
                    gap = next_gap();
                end
                repeat (gap) @(negedge clk);
                issue(is_d, k);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        drive_req(1'b0, 1'b0, '0, 1'b0, '0);
        drive_req(1'b1, 1'b0, '0, 1'b0, '0);
        lcg_state = 32'hc46c_0d5b;
        load_golden();
        cycle_limit = 40 * n_lines + 100;
        repeat (16) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst_n = 1'b1;
        check_reset_outputs();
        for (int p = 1; p <= max_phase; p++) begin
            fork
                run_port(1'b0, p);
                run_port(1'b1, p);
            join
        end
        repeat (4) @(negedge clk);
        assert (i_resp_total == i_lines)
            else abort_run($sformatf("instruction port saw %0d responses for %0d requests",
                                     i_resp_total, i_lines));
        assert (d_resp_total == d_lines)
            else abort_run($sformatf("data port saw %0d responses for %0d requests",
                                     d_resp_total, d_lines));
        $display("No errors");
        $finish;
    end

endmodule

/* verilog.f */
mem_bus_pkg.sv
mem_bus_arbiter.sv
bus_sram.sv
mem_bus_top.sv
tb_mem_bus.sv
